/* logic/pet_pkg.sv */
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types and memory-map constants for the bus FPGA
// Referenced by scoped name from the RTL and the testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package pet_pkg;

    // Bus command assembled from one SPI frame
    typedef struct packed {
        logic        rw_n;                              // 1 = host read, 0 = host write
        logic [16:0] addr;                              // 17-bit host address
        logic  [7:0] data;                              // Write data
    } spi_cmd_t;

    // Address decode flags
    typedef struct packed {
        logic ram;                                      // RAM selected
        logic io;                                       // Generic IO window
        logic pia1;                                     // PIA 1 at E810
        logic pia2;                                     // PIA 2 at E820
        logic via;                                      // VIA at E840
        logic readonly;                                 // ROM area, CPU writes blocked
        logic mirrored;                                 // Video RAM mirror
    } decode_t;

    // Owner of the current bus phase
    typedef enum logic {
        SLOT_SPI = 1'b0,
        SLOT_CPU = 1'b1
    } slot_e;

    // SPI command byte, bit 0 carries addr[16]
    typedef enum logic [7:0] {
        OP_WRITE = 8'h00,
        OP_READ  = 8'h80
    } spi_op_e;

    localparam logic [16:0] CTL_REG_ADDR    = 17'h0E80F;   // Bit 0 reset, bit 1 run
    localparam logic [16:0] GFX_REG_ADDR    = 17'h0E80F;   // Host read returns gfx_i
    localparam logic [16:0] KBD_MATRIX_BASE = 17'h0E800;   // First key row
    localparam int          KBD_ROWS        = 10;          // Rows E800..E809

    localparam logic [3:0]  PHASE_SPI_END   = 4'd3;        // Host slot is phases 0..3
    localparam logic [3:0]  PHASE_CPU_HIGH  = 4'd8;        // CPU clock high from here

endpackage

`default_nettype wire

/* logic/spi_bridge.sv */
`timescale 1ns/10ps
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SPI slave for the host processor. Turns 4-byte frames
// (cmd, addr hi, addr lo, data) into a bus command and
// shifts read data back out during the fourth byte
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module spi_bridge (
    input  logic              clk_16_i,
    input  logic              reset_i,
    input  logic              spi_sclk_i,               // Mode 0, sampled on rising edge
    input  logic              spi_cs_ni,
    input  logic              spi_rx_i,
    output logic              spi_tx_o,                 // Low while CS is high
    input  logic  [7:0]       spi_data_i,               // Read data to return
    output pet_pkg::spi_cmd_t spi_cmd_o,
    output logic              spi_valid_o,              // Command pending
    input  logic              spi_ready_i,              // Pulse from bus timing
    output logic              spi_ready_o               // Held until next CS fall
);
    logic [2:0] sclk_q;                                 // 2 sync flops plus edge history
    logic [2:0] cs_nq;
    logic [1:0] rx_q;
    logic [2:0] bit_cnt;
    logic [1:0] byte_cnt;
    logic [6:0] rx_shift;                               // Bits of the current byte
    logic [7:0] tx_shift;
    logic       load_tx;                                // Read data latched one cycle after ready

    wire       sclk_rise = sclk_q[1] && !sclk_q[2];
    wire       sclk_fall = !sclk_q[1] && sclk_q[2];
    wire       cs_active = !cs_nq[1];
    wire       cs_fall   = !cs_nq[1] && cs_nq[2];       // Start of a new frame
    wire [7:0] rx_byte   = {rx_shift, rx_q[1]};         // Byte completed by this edge

    always_ff @(posedge clk_16_i) begin
        if (reset_i) begin
            sclk_q <= '0;
            cs_nq  <= '1;                               // CS idles high
            rx_q   <= '0;
        end else begin
            sclk_q <= {sclk_q[1:0], spi_sclk_i};
            cs_nq  <= {cs_nq[1:0], spi_cs_ni};
            rx_q   <= {rx_q[0], spi_rx_i};
        end
    end

    always_ff @(posedge clk_16_i) begin
        if (reset_i) begin
            bit_cnt     <= '0;
            byte_cnt    <= '0;
            spi_valid_o <= 1'b0;
            spi_ready_o <= 1'b0;
            load_tx     <= 1'b0;
        end else begin
            load_tx <= spi_ready_i;
            if (spi_ready_i) begin                      // Bus cycle done
                spi_valid_o <= 1'b0;
                spi_ready_o <= 1'b1;
            end
            if (cs_fall) begin
                bit_cnt     <= '0;
                byte_cnt    <= '0;
                spi_ready_o <= 1'b0;
            end else if (cs_active && sclk_rise) begin
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7) begin
                    byte_cnt <= byte_cnt + 2'd1;
                    if (byte_cnt == 2'd2 && spi_cmd_o.rw_n) begin
                        spi_valid_o <= 1'b1;            // Read issues after address
                    end
                    if (byte_cnt == 2'd3 && !spi_cmd_o.rw_n) begin
                        spi_valid_o <= 1'b1;            // Write issues after data
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_16_i) begin
        if (cs_active && sclk_rise) begin
            rx_shift <= rx_byte[6:0];
            if (bit_cnt == 3'd7) begin
                case (byte_cnt)
                    2'd0: begin
                        spi_cmd_o.rw_n     <= (rx_byte & 8'hFE) == pet_pkg::OP_READ;
                        spi_cmd_o.addr[16] <= rx_byte[0];
                    end
                    2'd1:    spi_cmd_o.addr[15:8] <= rx_byte;
                    2'd2:    spi_cmd_o.addr[7:0]  <= rx_byte;
                    default: spi_cmd_o.data       <= rx_byte;
                endcase
            end
        end
        if (load_tx) begin
            tx_shift <= spi_data_i;
        end else if (cs_active && sclk_fall) begin
            tx_shift <= {tx_shift[6:0], 1'b0};          // MSB first
        end
    end

    assign spi_tx_o = cs_active && tx_shift[7];

endmodule

`default_nettype wire

/* logic/bus_timing.sv */
`timescale 1ns/10ps
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 16-phase bus cycle at 1 MHz. Phases 0..3 go to a pending
// host command, phases 4..15 to the CPU when it may run
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module bus_timing (
    input  logic           clk_16_i,
    input  logic           reset_i,
    output logic           clk_cpu_o,                   // 1 MHz CPU clock
    input  logic           spi_valid_i,                 // Host command pending
    output logic           spi_enable_o,                // Host owns the bus
    output logic           spi_ready_o,                 // One-cycle done pulse
    input  logic           cpu_valid_i,                 // CPU ready
    output logic           cpu_enable_o,                // CPU owns the bus
    output pet_pkg::slot_e slot_o
);
    logic [3:0] phase;

    wire [3:0] phase_next = phase + 4'd1;
    wire       cpu_start  = phase_next == (pet_pkg::PHASE_SPI_END + 4'd1);

    always_ff @(posedge clk_16_i) begin
        if (reset_i) begin
            phase        <= '0;
            spi_enable_o <= 1'b0;
            cpu_enable_o <= 1'b0;
        end else begin
            phase <= phase_next;
            if (phase_next == 4'd0) begin
                spi_enable_o <= spi_valid_i;            // Grant only if pending at phase 0
            end else if (phase_next > pet_pkg::PHASE_SPI_END) begin
                spi_enable_o <= 1'b0;
            end
            if (cpu_start) begin
                cpu_enable_o <= cpu_valid_i;            // Whole CPU slot or none
            end else if (phase_next <= pet_pkg::PHASE_SPI_END) begin
                cpu_enable_o <= 1'b0;
            end
        end
    end

    assign clk_cpu_o   = phase >= pet_pkg::PHASE_CPU_HIGH;      // Top bit of the counter
    assign spi_ready_o = spi_enable_o && (phase == pet_pkg::PHASE_SPI_END);
    assign slot_o      = (phase <= pet_pkg::PHASE_SPI_END) ? pet_pkg::SLOT_SPI
                                                           : pet_pkg::SLOT_CPU;

endmodule

`default_nettype wire

/* logic/pi_ctl.sv */
`timescale 1ns/10ps
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Host control register for CPU reset and CPU ready
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module pi_ctl (
    input  logic              clk_16_i,
    input  logic              reset_i,
    input  pet_pkg::spi_cmd_t spi_cmd_i,
    input  logic              spi_wr_en_i,              // Host write slot
    output logic              cpu_res_no,               // 0 = CPU held in reset
    output logic              cpu_ready_o               // 0 = halt, 1 = run
);
    logic res_q;
    logic run_q;

    always_ff @(posedge clk_16_i) begin
        if (reset_i) begin
            res_q <= 1'b1;                              // Power up with CPU in reset
            run_q <= 1'b0;
        end else if (spi_wr_en_i && spi_cmd_i.addr == pet_pkg::CTL_REG_ADDR) begin
            res_q <= spi_cmd_i.data[0];
            run_q <= spi_cmd_i.data[1];
        end
    end

    assign cpu_res_no  = !res_q;
    assign cpu_ready_o = run_q;

endmodule

`default_nettype wire

/* logic/address_decoding.sv */
`timescale 1ns/10ps
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CPU memory map decode into RAM, IO and chip-select flags
// Purely combinational
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module address_decoding (
    input  logic [15:0]      bus_addr_i,
    output pet_pkg::decode_t decode_o
);
    always_comb begin
        decode_o = '0;
        case (bus_addr_i[15:12])
            4'h8: begin                                 // Video RAM
                decode_o.ram      = 1'b1;
                decode_o.mirrored = 1'b1;
            end
            4'h9, 4'hA, 4'hB, 4'hC, 4'hD, 4'hF: begin   // BASIC, editor and kernal ROM
                decode_o.ram      = 1'b1;
                decode_o.readonly = 1'b1;
            end
            4'hE: begin
                if (!bus_addr_i[11]) begin              // E000..E7FF editor ROM
                    decode_o.ram      = 1'b1;
                    decode_o.readonly = 1'b1;
                end else begin
                    case (bus_addr_i[11:4])
                        8'h81:   decode_o.pia1 = 1'b1;
                        8'h82:   decode_o.pia2 = 1'b1;
                        8'h84:   decode_o.via  = 1'b1;
                        default: decode_o.io   = 1'b1;  // Rest of E800..EFFF
                    endcase
                end
            end
            default: decode_o.ram = 1'b1;               // 0000..7FFF main RAM
        endcase
    end

endmodule

`default_nettype wire

/* logic/keyboard.sv */
`timescale 1ns/10ps
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Keyboard matrix stand-in. The host uploads key rows, the
// CPU row select is snooped from PIA 1 port A and reads of
// port B are answered from the stored matrix
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module keyboard (
    input  logic              clk_16_i,
    input  logic              reset_i,
    input  pet_pkg::spi_cmd_t spi_cmd_i,
    input  logic              spi_wr_en_i,
    input  logic [1:0]        bus_addr_i,               // PIA register offset
    input  logic [7:0]        bus_data_i,
    input  logic              pia1_en_i,                // PIA 1 decoded
    input  logic              cpu_rd_en_i,
    input  logic              cpu_wr_en_i,
    output logic [7:0]        kbd_data_o,
    output logic              kbd_en_o                  // Intercepting port B read
);
    logic [7:0] kbd_rows [pet_pkg::KBD_ROWS];           // Active-low key state
    logic [3:0] row_sel;

    wire [16:0] row_offset = spi_cmd_i.addr - pet_pkg::KBD_MATRIX_BASE;
    wire        row_wr     = spi_wr_en_i && (row_offset < pet_pkg::KBD_ROWS);

    always_ff @(posedge clk_16_i) begin
        if (reset_i) begin
            for (int i = 0; i < pet_pkg::KBD_ROWS; i++) begin
                kbd_rows[i] <= 8'hFF;                   // No key pressed
            end
        end else if (row_wr) begin
            kbd_rows[row_offset[3:0]] <= spi_cmd_i.data;
        end
    end

    always_ff @(posedge clk_16_i) begin
        if (reset_i) begin
            row_sel <= '0;
        end else if (cpu_wr_en_i && pia1_en_i && bus_addr_i == 2'd0) begin
            row_sel <= bus_data_i[3:0];                 // Port A low nibble
        end
    end

    assign kbd_en_o   = cpu_rd_en_i && pia1_en_i && bus_addr_i == 2'd2;
    assign kbd_data_o = (row_sel < pet_pkg::KBD_ROWS) ? kbd_rows[row_sel] : 8'hFF;

endmodule

`default_nettype wire

/* logic/main.sv */
`timescale 1ns/10ps
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top level of the bus FPGA. Shares the system bus between
// the SPI host and the CPU, and drives RAM and chip selects
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module main (
    input  logic         clk_16_i,                      // 16 MHz system clock
    input  logic         reset_i,

    input  logic         bus_rw_ni,                     // 0 = CPU writing
    output logic         bus_rw_no,
    output logic         bus_rw_noe,
    input  logic [15:0]  bus_addr_i,
    output logic [16:0]  bus_addr_o,
    output logic         bus_addr_oe,
    input  logic  [7:0]  bus_data_i,
    output logic  [7:0]  bus_data_o,
    output logic         bus_data_oe,
    output logic [11:10] ram_addr_o,                    // RAM A11/A10 for VRAM mirror

    input  logic         spi1_sclk_i,
    input  logic         spi1_cs_ni,
    input  logic         spi1_rx_i,
    output logic         spi1_tx_o,
    output logic         spi_ready_no,                  // 0 = host command done

    output logic         clk_cpu_o,                     // 1 MHz CPU clock
    output logic         ram_oe_no,
    output logic         ram_we_no,

    output logic         cpu_res_nao,
    output logic         cpu_ready_o,                   // 0 = halt, 1 = run

    output logic         cpu_en_o,                      // CPU bus enable
    output logic         ram_ce_no,
    output logic         pia1_cs2_no,
    output logic         pia2_cs2_no,
    output logic         via_cs2_no,
    output logic         io_oe_no,

    input  logic         gfx_i                          // Graphics jumper
);
    pet_pkg::spi_cmd_t spi_cmd;
    pet_pkg::decode_t  dec;
    pet_pkg::slot_e    slot;
    logic        spi_valid;
    logic        spi_ready;                             // Pulse at end of host slot
    logic        spi_ready_out;
    logic        spi_en;
    logic  [7:0] spi_rd_data;                           // Latched host read data
    logic  [7:0] kbd_data;
    logic        kbd_en;

    spi_bridge spi_bridge (
        .clk_16_i   (clk_16_i),
        .reset_i    (reset_i),
        .spi_sclk_i (spi1_sclk_i),
        .spi_cs_ni  (spi1_cs_ni),
        .spi_rx_i   (spi1_rx_i),
        .spi_tx_o   (spi1_tx_o),
        .spi_data_i (spi_rd_data),
        .spi_cmd_o  (spi_cmd),
        .spi_valid_o(spi_valid),
        .spi_ready_i(spi_ready),
        .spi_ready_o(spi_ready_out)
    );

    bus_timing bus_timing (
        .clk_16_i    (clk_16_i),
        .reset_i     (reset_i),
        .clk_cpu_o   (clk_cpu_o),
        .spi_valid_i (spi_valid),
        .spi_enable_o(spi_en),
        .spi_ready_o (spi_ready),
        .cpu_valid_i (cpu_ready_o),
        .cpu_enable_o(cpu_en_o),
        .slot_o      (slot)
    );

    wire spi_rd_en = spi_en && spi_cmd.rw_n;
    wire spi_wr_en = spi_en && !spi_cmd.rw_n;
    wire cpu_rd_en = cpu_en_o && bus_rw_ni;
    wire cpu_wr_en = cpu_en_o && !bus_rw_ni;

    pi_ctl pi_ctl (
        .clk_16_i   (clk_16_i),
        .reset_i    (reset_i),
        .spi_cmd_i  (spi_cmd),
        .spi_wr_en_i(spi_wr_en),
        .cpu_res_no (cpu_res_nao),
        .cpu_ready_o(cpu_ready_o)
    );

    address_decoding address_decoding (
        .bus_addr_i(bus_addr_i),
        .decode_o  (dec)
    );

    keyboard keyboard (
        .clk_16_i   (clk_16_i),
        .reset_i    (reset_i),
        .spi_cmd_i  (spi_cmd),
        .spi_wr_en_i(spi_wr_en),
        .bus_addr_i (bus_addr_i[1:0]),
        .bus_data_i (bus_data_i),
        .pia1_en_i  (dec.pia1),
        .cpu_rd_en_i(cpu_rd_en),
        .cpu_wr_en_i(cpu_wr_en),
        .kbd_data_o (kbd_data),
        .kbd_en_o   (kbd_en)
    );

    // Keyboard intercept hides PIA 1 and the IO window
    assign pia1_cs2_no = !(dec.pia1 && !kbd_en && cpu_en_o);
    assign pia2_cs2_no = !(dec.pia2 && cpu_en_o);
    assign via_cs2_no  = !(dec.via && cpu_en_o);
    assign io_oe_no    = !(dec.io && !kbd_en && cpu_en_o);

    assign ram_ce_no = 1'b0;                            // RAM always selected
    assign ram_oe_no = !((dec.ram || slot == pet_pkg::SLOT_SPI) && (spi_rd_en || cpu_rd_en));
    assign ram_we_no = !(spi_wr_en || (cpu_wr_en && clk_cpu_o && !dec.readonly));

    always_ff @(posedge clk_16_i) begin
        if (spi_ready && slot == pet_pkg::SLOT_SPI && spi_cmd.rw_n) begin   // Phase 3
            if (spi_cmd.addr == pet_pkg::GFX_REG_ADDR) begin
                spi_rd_data <= {7'h0, gfx_i};
            end else begin
                spi_rd_data <= bus_data_i;
            end
        end
    end

    assign spi_ready_no = !spi_ready_out;

    // FPGA owns address and R/W whenever the CPU does not
    assign bus_addr_oe      = !cpu_en_o;
    assign bus_rw_noe       = bus_addr_oe;
    assign bus_rw_no        = !spi_wr_en;
    assign bus_addr_o[15:0] = spi_cmd.addr[15:0];
    assign bus_addr_o[16]   = bus_addr_oe ? spi_cmd.addr[16] : 1'b0;   // CPU sees low 64K

    assign ram_addr_o = spi_en      ? spi_cmd.addr[11:10]              // Host sees full RAM
                      : dec.mirrored ? 2'b00                           // 1K VRAM mirrored 4x
                      : bus_addr_i[11:10];

    assign bus_data_oe = spi_wr_en || kbd_en;
    assign bus_data_o  = kbd_en ? kbd_data : spi_cmd.data;

endmodule

`default_nettype wire

/* sim/main_assert.sv */
`timescale 1ns/10ps
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus sharing rules of the top level, bound into main
// Host and CPU slots, ROM protection and data bus ownership
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module main_assert (
    input logic        clk_16_i,
    input logic        reset_i,
    input logic        spi_en_i,                        // Host slot granted
    input logic        cpu_en_i,                        // CPU slot granted
    input logic        cpu_rw_ni,                       // 0 = CPU write
    input logic [15:0] bus_addr_i,                      // CPU address
    input logic        readonly_i,                      // ROM area decoded
    input logic        ram_we_ni,
    input logic        bus_data_oe_i
);
    int fail_count = 0;

    wire kbd_port = (bus_addr_i[15:4] == 12'hE81) && (bus_addr_i[1:0] == 2'd2);   // PIA 1 port B

    enables_exclusive: assert property (@(posedge clk_16_i) disable iff (reset_i)
        !(spi_en_i && cpu_en_i)) else begin
        $error("host and CPU enables high together");
        fail_count++;
    end

    rom_protected: assert property (@(posedge clk_16_i) disable iff (reset_i)
        !(!ram_we_ni && cpu_en_i && !cpu_rw_ni && readonly_i)) else begin
        $error("RAM write strobe on a CPU write to the ROM area");
        fail_count++;
    end

    data_oe_owner: assert property (@(posedge clk_16_i) disable iff (reset_i)
        bus_data_oe_i |-> ((spi_en_i && !ram_we_ni) ||
                           (cpu_en_i && cpu_rw_ni && kbd_port))) else begin
        $error("data bus driven outside a host write or keyboard read");
        fail_count++;
    end

endmodule

`default_nettype wire

/* sim/main_tb.sv */
`timescale 1ns/10ps
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the bus FPGA. Drives SPI frames from the host
// side, models the RAM and the CPU bus, and runs a table of
// host and CPU accesses against expected results
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module main_tb;
    typedef enum logic [2:0] {T_HOST_WR, T_HOST_RD, T_DECODE, T_CPU_WR, T_KBD_RD} test_op_e;
    typedef struct packed {
        test_op_e    op;
        logic [16:0] addr;                              // Host address or CPU address
        logic  [7:0] data;
        logic  [7:0] exp_val;                           // Meaning depends on op
    } test_t;

    localparam int NUM_TESTS  = 17;
    localparam int WAIT_LIMIT = 64;                     // Clocks per wait loop

    logic         clk_16_i, reset_i, gfx_i;
    logic         bus_rw_ni;
    logic [15:0]  bus_addr_i;
    logic  [7:0]  cpu_data;                             // CPU side of the data bus
    wire   [7:0]  bus_data_i;
    logic         spi1_sclk_i, spi1_cs_ni, spi1_rx_i;
    logic         bus_rw_no, bus_rw_noe, bus_addr_oe, bus_data_oe;
    logic [16:0]  bus_addr_o;
    logic  [7:0]  bus_data_o;
    logic [11:10] ram_addr_o;
    logic         spi1_tx_o, spi_ready_no, clk_cpu_o, ram_oe_no, ram_we_no;
    logic         cpu_res_nao, cpu_ready_o, cpu_en_o, ram_ce_no;
    logic         pia1_cs2_no, pia2_cs2_no, via_cs2_no, io_oe_no;
    logic  [7:0]  ram [0:131071];                       // 128K system RAM
    test_t        tests [NUM_TESTS];

    main dut0 (.*);

    bind main main_assert assert0 (
        .clk_16_i     (clk_16_i),
        .reset_i      (reset_i),
        .spi_en_i     (spi_en),
        .cpu_en_i     (cpu_en_o),
        .cpu_rw_ni    (bus_rw_ni),
        .bus_addr_i   (bus_addr_i),
        .readonly_i   (dec.readonly),
        .ram_we_ni    (ram_we_no),
        .bus_data_oe_i(bus_data_oe)
    );

    always #10 clk_16_i = !clk_16_i;                    // 50 MHz sim clock, 20 ns

    // RAM sees the host address or the CPU address, with A11/A10 from the FPGA
    wire [16:0] ram_a = bus_addr_oe ? {bus_addr_o[16:12], ram_addr_o, bus_addr_o[9:0]}
                                    : {1'b0, bus_addr_i[15:12], ram_addr_o, bus_addr_i[9:0]};

    assign bus_data_i = (!ram_ce_no && !ram_oe_no) ? ram[ram_a] : cpu_data;

    always @(posedge clk_16_i) begin
        if (!ram_ce_no && !ram_we_no) begin
            ram[ram_a] <= bus_data_oe ? bus_data_o : cpu_data;
            if (bus_addr_oe) begin                      // Host write, FPGA drives R/W
                check_value("bus_rw_no on host write", bus_rw_no, 1'b0);
                check_value("bus_rw_noe on host write", bus_rw_noe, 1'b1);
            end
        end
    end

    always @(negedge clk_16_i) begin
        check_value("assertion failure count", dut0.assert0.fail_count, 32'd0);
    end

    task automatic tick(input int n);
        repeat (n) @(negedge clk_16_i);
    endtask

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("Testbench failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("Timed out at %0t ns waiting for %s", $time, what);
        $display("Testbench failed");
        $fatal(1, "timeout");
    endtask

    task automatic shift_spi_byte(input logic [7:0] tx, output logic [7:0] rx);
        for (int i = 7; i >= 0; i--) begin
            spi1_rx_i = tx[i];                          // MSB first
            tick(4);
            rx[i] = spi1_tx_o;                          // Sampled at the rising edge
            spi1_sclk_i = 1'b1;
            tick(4);
            spi1_sclk_i = 1'b0;
        end
    endtask

    task automatic wait_spi_ready();
        int n;
        n = 0;
        while (spi_ready_no && n < WAIT_LIMIT) begin
            tick(1);
            n++;
        end
        if (spi_ready_no) timeout_fail("spi_ready_no");
    endtask

    task automatic wait_cpu_enable(input logic level);
        int n;
        n = 0;
        while (cpu_en_o !== level && n < WAIT_LIMIT) begin
            tick(1);
            n++;
        end
        if (cpu_en_o !== level) timeout_fail("cpu_en_o");
    endtask

    task automatic host_transfer(input logic rd, input logic [16:0] addr,
                                 input logic [7:0] wdata, output logic [7:0] rdata);
        logic [7:0] cmd;
        logic [7:0] unused;
        cmd = (rd ? pet_pkg::OP_READ : pet_pkg::OP_WRITE) | {7'h0, addr[16]};
        spi1_cs_ni = 1'b0;
        tick(4);
        shift_spi_byte(cmd, unused);
        shift_spi_byte(addr[15:8], unused);
        shift_spi_byte(addr[7:0], unused);
        if (rd) wait_spi_ready();                       // Read data ready before byte 4
        shift_spi_byte(wdata, rdata);
        if (!rd) wait_spi_ready();
        tick(4);
        spi1_cs_ni = 1'b1;
        tick(8);
    endtask

    // CPU changes address in the host slot and the access runs in the next CPU slot
    task automatic start_cpu_access(input logic [15:0] addr, input logic [7:0] data,
                                    input logic rw_n);
        wait_cpu_enable(1'b0);
        bus_addr_i = addr;
        cpu_data   = data;
        bus_rw_ni  = rw_n;
        wait_cpu_enable(1'b1);
    endtask

    task automatic apply_test(input test_t t);
        logic [7:0] rdata;
        logic       seen;
        case (t.op)
            T_HOST_WR: begin
                host_transfer(1'b0, t.addr, t.data, rdata);
                check_value("RAM byte after host write", ram[t.addr], t.data);
            end
            T_HOST_RD: begin
                host_transfer(1'b1, t.addr, 8'h00, rdata);
                check_value("host read data", rdata, t.exp_val);
            end
            T_DECODE: begin
                start_cpu_access(t.addr[15:0], t.data, 1'b1);
                check_value("decode outputs", {ram_oe_no, pia1_cs2_no, pia2_cs2_no,
                            via_cs2_no, io_oe_no, ram_addr_o}, t.exp_val[6:0]);
            end
            T_CPU_WR: begin
                start_cpu_access(t.addr[15:0], t.data, 1'b0);
                seen = 1'b0;
                for (int n = 0; n < 16 && cpu_en_o; n++) begin
                    if (!ram_we_no) begin
                        seen = 1'b1;
                        check_value("clk_cpu_o during RAM write", clk_cpu_o, 1'b1);
                    end
                    tick(1);
                end
                check_value("RAM write strobe seen", seen, t.exp_val[0]);
            end
            default: begin                              // Keyboard port B read
                start_cpu_access(t.addr[15:0], t.data, 1'b1);
                check_value("bus_data_oe on key read", bus_data_oe, 1'b1);
                check_value("key row data", bus_data_o, t.exp_val);
                check_value("pia1_cs2_no on key read", pia1_cs2_no, 1'b1);
            end
        endcase
    endtask

    initial begin
        logic [31:0] rnd;
        logic [16:0] ram_addr;
        logic  [7:0] ram_byte;
        logic  [7:0] key_byte;
        logic  [7:0] rdata;
        clk_16_i    = 1'b0;
        reset_i     = 1'b1;
        gfx_i       = 1'b0;
        bus_rw_ni   = 1'b1;
        bus_addr_i  = 16'h0100;
        cpu_data    = 8'h00;
        spi1_sclk_i = 1'b0;
        spi1_cs_ni  = 1'b1;
        spi1_rx_i   = 1'b0;
        rnd = $urandom(32'h6443_631a);
        rnd = $urandom;
        ram_addr = {rnd[16], 1'b0, rnd[14:0]};          // Plain RAM in either bank
        rnd = $urandom;
        ram_byte = rnd[7:0];
        key_byte = rnd[15:8];

        // Selects packed as {ram_oe, pia1, pia2, via, io, ram_addr[11:10]}
        tests[0]  = '{T_HOST_WR, ram_addr, ram_byte, 8'h00};
        tests[1]  = '{T_HOST_RD, ram_addr, 8'h00, ram_byte};
        tests[2]  = '{T_DECODE, 17'h00100, 8'h00, 8'b0_0_1111_00};
        tests[3]  = '{T_DECODE, 17'h08400, 8'h00, 8'b0_0_1111_00};   // Mirror forces 00
        tests[4]  = '{T_DECODE, 17'h08C00, 8'h00, 8'b0_0_1111_00};
        tests[5]  = '{T_DECODE, 17'h0E810, 8'h00, 8'b0_1_0111_10};
        tests[6]  = '{T_DECODE, 17'h0E820, 8'h00, 8'b0_1_1011_10};
        tests[7]  = '{T_DECODE, 17'h0E840, 8'h00, 8'b0_1_1101_10};
        tests[8]  = '{T_DECODE, 17'h0E880, 8'h00, 8'b0_1_1110_10};
        tests[9]  = '{T_DECODE, 17'h0F000, 8'h00, 8'b0_0_1111_00};
        tests[10] = '{T_CPU_WR, 17'h01000, 8'h5A, 8'h01};
        tests[11] = '{T_CPU_WR, 17'h0F000, 8'hA5, 8'h00};            // ROM, no strobe
        tests[12] = '{T_HOST_WR, pet_pkg::KBD_MATRIX_BASE + 17'd3, key_byte, 8'h00};
        tests[13] = '{T_CPU_WR, 17'h0E810, 8'h03, 8'h01};            // Row select 3
        tests[14] = '{T_KBD_RD, 17'h0E812, 8'h00, key_byte};
        tests[15] = '{T_CPU_WR, 17'h0E810, 8'h0C, 8'h01};            // Row 12 is out of range
        tests[16] = '{T_KBD_RD, 17'h0E812, 8'h00, 8'hFF};

        repeat (5) @(negedge clk_16_i);
        reset_i = 1'b0;

        check_value("cpu_res_nao after reset", cpu_res_nao, 1'b0);
        check_value("cpu_ready_o after reset", cpu_ready_o, 1'b0);
        check_value("spi_ready_no after reset", spi_ready_no, 1'b1);
        check_value("bus_data_oe after reset", bus_data_oe, 1'b0);
        check_value("bus_addr_oe after reset", bus_addr_oe, 1'b1);
        for (int n = 0; n < 40; n++) begin              // CPU halted, no CPU slot
            check_value("cpu_en_o while halted", cpu_en_o, 1'b0);
            tick(1);
        end
        host_transfer(1'b0, pet_pkg::CTL_REG_ADDR, 8'h03, rdata);
        check_value("cpu_ready_o after run", cpu_ready_o, 1'b1);
        check_value("cpu_res_nao with reset bit set", cpu_res_nao, 1'b0);
        repeat (3) begin                                // One CPU slot per bus cycle
            wait_cpu_enable(1'b0);
            wait_cpu_enable(1'b1);
        end

        for (int i = 0; i < NUM_TESTS; i++) begin
            apply_test(tests[i]);
        end

        gfx_i = 1'b1;
        host_transfer(1'b1, pet_pkg::GFX_REG_ADDR, 8'h00, rdata);
        check_value("graphics bit high", rdata, 8'h01);
        gfx_i = 1'b0;
        host_transfer(1'b1, pet_pkg::GFX_REG_ADDR, 8'h00, rdata);
        check_value("graphics bit low", rdata, 8'h00);

        if (dut0.assert0.fail_count != 0) begin
            $display("Testbench failed");
            $fatal(1, "assertion failure");
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* list.f */
logic/pet_pkg.sv
logic/spi_bridge.sv
logic/bus_timing.sv
logic/pi_ctl.sv
logic/address_decoding.sv
logic/keyboard.sv
logic/main.sv
sim/main_assert.sv
sim/main_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then scan the log
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module main_tb \
    -f list.f -Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Build failed, see build.log"
    exit 1
fi

./obj_dir/Vmain_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
    exit 1
fi
exit 0
